//--- src.f
bombPkg.sv
slowClockGen.sv
bombFsm.sv
bombCounter.sv
sevenSegDriver.sv
bombTop.sv
bomb_assertions.sv
bombTb.sv

//--- run.sh
#!/bin/sh
# Build and run the bomb timer testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --assert --top-module bombTb -f src.f -o simBomb \
	&& ./obj_dir/simBomb +verilator+error+limit+1000 > sim.log 2>&1 \
	|| echo "Build or simulation exited with an error"
[ -f sim.log ] && cat sim.log
grep -qx "TB PASSED" sim.log && exit 0 || exit 1

//--- bombTb.sv
/*
 * Bomb timer testbench
 * Drives start and wait keys, models the count from its own slow phase
 * counter and checks both digits on every falling clock edge
 */
`timescale 1ns/1ps
`default_nettype none

module bombTb;

	import bombPkg::*;

	localparam int presetValue = 12;                            // Count after arming
	localparam int watchdogCycles = 40 * 2 * halfSecondCycles;  // 40 seconds
	localparam int modeIdle = 0;
	localparam int modeArm = 1;
	localparam int modeRun = 2;
	localparam int modePause = 3;
	localparam int modeDelay = 4;
	localparam int modeLamp = 5;

	logic clk = 1'b0;      // Low before any process starts
	logic resetN;
	logic startN;
	logic waitN;
	segPattern segTens;
	segPattern segOnes;

	int errCount;          // Display mismatches
	int unsigned edgeCnt;  // Edges since reset release
	int mode;              // Expected FSM phase
	int modelCount;        // Expected count
	logic lampOn;          // Expected blink phase
	logic preLvl;          // Slow level before the edge
	logic preTick;         // Second tick before the edge
	logic [13:0] expSegs;
	string testName;

	bombTop dut_i (
		.clk     (clk),
		.resetN  (resetN),
		.startN  (startN),
		.waitN   (waitN),
		.segTens (segTens),
		.segOnes (segOnes)
	);

	initial begin
		forever #50 clk = ~clk;
	end

	// Segment a in bit 0
	function automatic segPattern digitSegments(input int digit);
		case (digit)
			0: return 7'h3F;
			1: return 7'h06;
			2: return 7'h5B;
			3: return 7'h4F;
			4: return 7'h66;
			5: return 7'h6D;
			6: return 7'h7D;
			7: return 7'h07;
			8: return 7'h7F;
			default: return 7'h6F;  // Nine
		endcase
	endfunction

	// Expected behaviour from keys sampled before the edge
	always @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			edgeCnt = 0;
			mode = modeIdle;
			modelCount = 0;
			lampOn = 1'b0;
		end else begin
			preLvl = ((edgeCnt / halfSecondCycles) % 2) == 1;
			preTick = (edgeCnt % (2 * halfSecondCycles)) == halfSecondCycles;
			edgeCnt++;
			case (mode)
				modeIdle: if (!startN) mode = modeArm;
				modeArm: begin
					modelCount = presetValue;  // Loads while key held
					if (startN)
						mode = modeRun;
				end
				modeRun: begin
					if (modelCount == 0) begin  // Time up beats wait
						mode = modeLamp;
						lampOn = 1'b1;
					end else begin
						if (preTick)
							modelCount--;
						if (!waitN)
							mode = modePause;
					end
				end
				modePause: if (waitN && preLvl) mode = modeDelay;
				modeDelay: if (!preLvl) mode = modeRun;
				default: lampOn = !preLvl;  // Blink follows slow level
			endcase
		end
	end

	always @(negedge clk) begin
		if (mode == modeIdle)
			expSegs = {blankPattern, blankPattern};
		else if (mode == modeLamp)
			expSegs = lampOn ? {fullPattern, fullPattern} : {blankPattern, blankPattern};
		else
			expSegs = {digitSegments(modelCount / 10), digitSegments(modelCount % 10)};
		assert ({segTens, segOnes} == expSegs)
			else begin
				$display("Fail %s: expected %h actual %h", testName, expSegs,
					{segTens, segOnes});
				errCount++;
			end
	end

	initial begin
		repeat (watchdogCycles) @(posedge clk);
		$display("Watchdog expired before the tests finished");
		$display("TB FAILED");
		$finish;
	end

	task automatic waitCycles(input int unsigned n);
		repeat (n) @(posedge clk);
		#1;  // Inputs change just after the edge
	endtask

	task automatic armAndRelease(input int unsigned holdCycles);
		startN = 1'b0;
		waitCycles(holdCycles);
		startN = 1'b1;
	endtask

	task automatic pauseCount();
		int unsigned holdCycles;
		holdCycles = 1 + ($urandom % 30);
		waitN = 1'b0;
		waitCycles(holdCycles);
		waitN = 1'b1;
	endtask

	task automatic waitForCount(input int value);
		while (modelCount != value)
			waitCycles(1);
	endtask

	task automatic applyReset();
		resetN = 1'b0;
		waitCycles(3);
		resetN = 1'b1;
	endtask

	initial begin
		errCount = 0;
		resetN = 1'b0;
		startN = 1'b1;
		waitN = 1'b1;
		testName = "reset";
		void'($urandom(32'he663_9f4e));
		repeat (3) @(posedge clk);
		#1 resetN = 1'b1;
		testName = "idleBlank";
		waitCycles(8);
		testName = "armLoad";
		armAndRelease(6);
		testName = "countDown";
		waitForCount(9);
		testName = "pauseHold";
		pauseCount();
		waitForCount(5);
		pauseCount();
		testName = "lampBlink";
		while (mode != modeLamp)
			waitCycles(1);
		waitCycles(6 * halfSecondCycles);
		testName = "midReset";
		applyReset();
		armAndRelease(4);
		waitForCount(10);
		applyReset();
		waitCycles(5);
		testName = "reload";
		armAndRelease(4);
		waitCycles(3 * halfSecondCycles);
		$display("Summary: %0d display errors, %0d assertion errors", errCount,
			dut_i.bombAssertions_i.assertFails);
		if (errCount == 0 && dut_i.bombAssertions_i.assertFails == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- bomb_assertions.sv
/*
 * Bomb timer assertions
 * Bound into bombTop, watching FSM state, counter and display outputs
 */
`timescale 1ns/1ps
`default_nettype none

module bombAssertions (
	input logic clk,
	input logic resetN,
	input bombPkg::bombState prState,   // FSM present state
	input logic countLoadN,
	input bombPkg::bcdDigit tensDigit,
	input bombPkg::bcdDigit onesDigit,
	input bombPkg::segPattern segTens,
	input bombPkg::segPattern segOnes
);

	import bombPkg::*;

	int unsigned assertFails = 0;  // Failed assertion tally

	// BCD digits compare like plain numbers
	countNoRise: assert property (@(posedge clk) disable iff (!resetN)
		countLoadN |=> {tensDigit, onesDigit} <= $past({tensDigit, onesDigit}))
		else begin
			$error("Count rose without a load");
			assertFails++;
		end

	lampOnFull: assert property (@(posedge clk) disable iff (!resetN)
		(prState == stLampOn) |-> (segTens == fullPattern && segOnes == fullPattern))
		else begin
			$error("Lamp on phase without all segments lit");
			assertFails++;
		end

	lampOffBlank: assert property (@(posedge clk) disable iff (!resetN)
		(prState == stLampOff) |-> (segTens == blankPattern && segOnes == blankPattern))
		else begin
			$error("Lamp off phase with segments lit");
			assertFails++;
		end

	// Only the run state may step the count
	holdOutsideRun: assert property (@(posedge clk) disable iff (!resetN)
		(countLoadN && (prState != stRun)) |=> $stable({tensDigit, onesDigit}))
		else begin
			$error("Count changed outside the run state");
			assertFails++;
		end

	idleAfterReset: assert property (@(posedge clk) $rose(resetN) |-> (prState == stIdle))
		else begin
			$error("State not idle after reset");
			assertFails++;
		end

endmodule

bind bombTop bombAssertions bombAssertions_i (
	.clk         (clk),
	.resetN      (resetN),
	.prState     (bombFsm_i.prState),
	.countLoadN  (countLoadN),
	.tensDigit   (tensDigit),
	.onesDigit   (onesDigit),
	.segTens     (segTens),
	.segOnes     (segOnes)
);

`default_nettype wire

//--- bombTop.sv
/*
 * Bomb timer top level
 * Connects slow clock, FSM, BCD counter and display driver
 */
`timescale 1ns/1ps
`default_nettype none

module bombTop (
	input  logic clk,
	input  logic resetN,
	input  logic startN,                 // Start key, active low
	input  logic waitN,                  // Pause key, active low
	output bombPkg::segPattern segTens,
	output bombPkg::segPattern segOnes
);

	import bombPkg::*;

	logic slowClken;    // Blink level
	logic secondTick;   // One-second pulse
	logic countEnable;
	logic countLoadN;
	logic lampEnable;
	logic lampTest;
	logic tcSec;        // Count at 00
	bcdDigit tensDigit;
	bcdDigit onesDigit;

	slowClockGen slowClockGen_i (
		.clk        (clk),
		.resetN     (resetN),
		.slowClken  (slowClken),
		.secondTick (secondTick)
	);

	bombFsm bombFsm_i (
		.clk         (clk),
		.resetN      (resetN),
		.startN      (startN),
		.waitN       (waitN),
		.slowClken   (slowClken),
		.tcSec       (tcSec),
		.countEnable (countEnable),
		.countLoadN  (countLoadN),
		.lampEnable  (lampEnable),
		.lampTest    (lampTest)
	);

	bombCounter bombCounter_i (
		.clk         (clk),
		.resetN      (resetN),
		.countLoadN  (countLoadN),
		.countEnable (countEnable),
		.secondTick  (secondTick),
		.tensDigit   (tensDigit),
		.onesDigit   (onesDigit),
		.tcSec       (tcSec)
	);

	sevenSegDriver sevenSegDriver_i (
		.tensDigit  (tensDigit),
		.onesDigit  (onesDigit),
		.lampEnable (lampEnable),
		.lampTest   (lampTest),
		.segTens    (segTens),
		.segOnes    (segOnes)
	);

endmodule

`default_nettype wire

//--- sevenSegDriver.sv
/*
 * Seven-segment driver
 * Decodes both BCD digits; lamp test lights every segment and a
 * disabled display goes blank
 */
`timescale 1ns/1ps
`default_nettype none

module sevenSegDriver (
	input  bombPkg::bcdDigit tensDigit,
	input  bombPkg::bcdDigit onesDigit,
	input  logic lampEnable,            // Low blanks both digits
	input  logic lampTest,              // High lights all segments
	output bombPkg::segPattern segTens,
	output bombPkg::segPattern segOnes
);

	import bombPkg::*;

	segPattern decTens;  // Plain decode of tens
	segPattern decOnes;  // Plain decode of ones

	assign decTens = bcdToSeg(tensDigit);
	assign decOnes = bcdToSeg(onesDigit);

	// Lamp test has priority over blanking
	always_comb begin
		if (lampTest) begin
			segTens = fullPattern;
			segOnes = fullPattern;
		end else if (!lampEnable) begin
			segTens = blankPattern;
			segOnes = blankPattern;
		end else begin
			segTens = decTens;
			segOnes = decOnes;
		end
	end

endmodule

`default_nettype wire

//--- bombCounter.sv
/*
 * Bomb down counter
 * Two BCD digits counting down once per second tick, loaded with
 * the preset, flagging terminal count at 00
 */
`timescale 1ns/1ps
`default_nettype none

module bombCounter (
	input  logic clk,
	input  logic resetN,
	input  logic countLoadN,             // Load preset, active low
	input  logic countEnable,            // From FSM run state
	input  logic secondTick,             // One per second
	output bombPkg::bcdDigit tensDigit,
	output bombPkg::bcdDigit onesDigit,
	output logic tcSec                   // Both digits zero
);

	import bombPkg::*;

	logic decrement;   // Step down this cycle
	logic onesBorrow;  // Ones wraps 0 to 9

	assign tcSec = (tensDigit == bcdDigit'(0)) && (onesDigit == bcdDigit'(0));

	// Guard at 00 keeps the count from wrapping to 99
	assign decrement  = countEnable && secondTick && !tcSec;
	assign onesBorrow = (onesDigit == bcdDigit'(0));

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			tensDigit <= '0;  // Holds 00 until armed
			onesDigit <= '0;
		end else if (!countLoadN) begin
			tensDigit <= presetTens;
			onesDigit <= presetOnes;
		end else if (decrement) begin
			if (onesBorrow) begin
				onesDigit <= bcdDigit'(9);
				tensDigit <= tensDigit - 1'b1;  // Borrow from tens
			end else begin
				onesDigit <= onesDigit - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- bombFsm.sv
/*
 * Bomb timer state machine
 * Moore FSM sequencing arm, run, pause, resume delay and the final
 * blink; a pause never detonates and always waits a full slow phase
 */
`timescale 1ns/1ps
`default_nettype none

module bombFsm (
	input  logic clk,
	input  logic resetN,
	input  logic startN,       // Start key, active low
	input  logic waitN,        // Pause key, active low
	input  logic slowClken,    // Slow blink level
	input  logic tcSec,        // Count reached 00
	output logic countEnable,  // Counter may decrement
	output logic countLoadN,   // Load preset, active low
	output logic lampEnable,   // Display on
	output logic lampTest      // Force all segments on
);

	import bombPkg::*;

	bombState prState;   // Present state
	bombState nxtState;  // Next state

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			prState <= stIdle;
		else
			prState <= nxtState;
	end

	// Next state, transitions only
	always_comb begin
		nxtState = prState;  // Hold by default
		case (prState)
			stIdle: begin
				if (!startN)
					nxtState = stArm;
			end
			stArm: begin
				if (startN)  // Run starts on key release
					nxtState = stRun;
			end
			stRun: begin
				if (tcSec)  // Time is up, wins over wait
					nxtState = stLampOn;
				else if (!waitN)
					nxtState = stPause;
			end
			stPause: begin
				if (waitN && slowClken)  // Released, slow phase high
					nxtState = stDelay;
			end
			stDelay: begin
				if (!slowClken)  // Rest of the high phase
					nxtState = stRun;
			end
			stLampOn: begin
				if (slowClken)
					nxtState = stLampOff;
			end
			stLampOff: begin
				if (!slowClken)
					nxtState = stLampOn;
			end
			default: nxtState = stIdle;  // Unused code 7
		endcase
	end

	// Moore outputs from the present state only
	always_comb begin
		countEnable = 1'b0;
		countLoadN  = 1'b1;
		lampEnable  = 1'b1;
		lampTest    = 1'b0;
		case (prState)
			stIdle:    lampEnable = 1'b0;  // Display dark until armed
			stArm:     countLoadN = 1'b0;  // Preset loads while key held
			stRun:     countEnable = 1'b1;
			stLampOn:  lampTest = 1'b1;    // Blink on phase
			stLampOff: lampEnable = 1'b0;  // Blink off phase
			default: begin
				countEnable = 1'b0;  // Pause and delay just hold
			end
		endcase
	end

endmodule

`default_nettype wire

//--- slowClockGen.sv
/*
 * Slow clock generator
 * Divides clk into the slow blink level and a one-cycle tick on each
 * rising edge of that level, one tick per second
 */
`timescale 1ns/1ps
`default_nettype none

module slowClockGen (
	input  logic clk,
	input  logic resetN,
	output logic slowClken,  // Toggles every halfSecondCycles
	output logic secondTick  // Pulse on rising slowClken
);

	import bombPkg::*;

	phaseCount phaseCnt;  // Cycles within current phase
	logic slowDly;        // slowClken one cycle late
	logic phaseWrap;

	assign phaseWrap = (phaseCnt == phaseCount'(halfSecondCycles - 1));

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			phaseCnt  <= '0;
			slowClken <= 1'b0;  // Starts low
			slowDly   <= 1'b0;
		end else begin
			slowDly <= slowClken;
			if (phaseWrap) begin
				phaseCnt  <= '0;
				slowClken <= ~slowClken;
			end else begin
				phaseCnt <= phaseCnt + 1'b1;
			end
		end
	end

	assign secondTick = slowClken & ~slowDly;  // High for one cycle

endmodule

`default_nettype wire

//--- bombPkg.sv
/*
 * Bomb timer package
 * Shared widths, FSM state encoding, timing and preset constants,
 * and the BCD to seven-segment decode used by the display path
 */
`default_nettype none

package bombPkg;

	typedef logic [3:0] bcdDigit;    // One decimal digit
	typedef logic [6:0] segPattern;  // Segment a in bit 0, active high

	typedef enum logic [2:0] {
		stIdle,
		stArm,
		stRun,
		stPause,
		stDelay,
		stLampOn,
		stLampOff
	} bombState;

	localparam int unsigned halfSecondCycles = 10;  // Short for simulation
	localparam int unsigned phaseWidth = $clog2(halfSecondCycles);
	typedef logic [phaseWidth-1:0] phaseCount;      // Slow clock phase counter

	localparam bcdDigit presetTens = 4'd1;  // Preset reads 12
	localparam bcdDigit presetOnes = 4'd2;

	localparam segPattern blankPattern = 7'h00;  // All segments off
	localparam segPattern fullPattern  = 7'h7F;  // Lamp test, all on

	// Segment order g f e d c b a, MSB first
	function automatic segPattern bcdToSeg(input bcdDigit digit);
		case (digit)
			4'd0:    return 7'h3F;
			4'd1:    return 7'h06;
			4'd2:    return 7'h5B;
			4'd3:    return 7'h4F;
			4'd4:    return 7'h66;
			4'd5:    return 7'h6D;
			4'd6:    return 7'h7D;
			4'd7:    return 7'h07;
			4'd8:    return 7'h7F;
			4'd9:    return 7'h6F;
			default: return blankPattern;  // Non-BCD codes stay dark
		endcase
	endfunction

endpackage

`default_nettype wire
